// ==== hdl/rv32i_pkg.sv ====
`default_nettype none

package rv32i_pkg;

    localparam int xlen = 32;
    localparam int reg_addr_w = 5;
    localparam int reg_count = 1 << reg_addr_w;

    typedef enum logic [6:0] {
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_branch = 7'b1100011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_op_imm = 7'b0010011,
        opc_op     = 7'b0110011
    } rv32i_opcode_t;

    typedef enum logic [2:0] {
        imm_none,
        imm_i,
        imm_s,
        imm_b,
        imm_u,
        imm_j
    } imm_fmt_t;

    // Encodings follow the branch funct3 field
    typedef enum logic [2:0] {
        cmp_beq  = 3'b000,
        cmp_bne  = 3'b001,
        cmp_blt  = 3'b100,
        cmp_bge  = 3'b101,
        cmp_bltu = 3'b110,
        cmp_bgeu = 3'b111
    } cmp_op_t;

    typedef enum logic {
        cmp_src_rs2,
        cmp_src_imm
    } cmp_src_t;

    typedef struct packed {
        logic [6:0]            funct7;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]           imm_11_0;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]            imm_11_5;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm_4_0;
        logic [6:0]            opcode;
    } s_fmt_t;

    typedef struct packed {
        logic                  imm_12;
        logic [5:0]            imm_10_5;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [3:0]            imm_4_1;
        logic                  imm_11;
        logic [6:0]            opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0]           imm_31_12;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } u_fmt_t;

    typedef struct packed {
        logic                  imm_20;
        logic [9:0]            imm_10_1;
        logic                  imm_11;
        logic [7:0]            imm_19_12;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } j_fmt_t;

    typedef union packed {
        logic [xlen-1:0] raw;
        r_fmt_t          r;
        i_fmt_t          i;
        s_fmt_t          s;
        b_fmt_t          b;
        u_fmt_t          u;
        j_fmt_t          j;
    } rv32i_instr_u;

    typedef struct packed {
        rv32i_opcode_t opcode;
        logic [2:0]    alu_op;
        logic          alu_alt;
        cmp_op_t       cmp_op;
        cmp_src_t      cmp_src;
        imm_fmt_t      imm_fmt;
        logic          rd_we;
        logic          mem_rd;
        logic          mem_wr;
        logic          is_branch;
        logic          is_jump;
        logic          illegal;
    } rv32i_ctrl_t;

    typedef struct packed {
        rv32i_instr_u    instr;
        logic [xlen-1:0] pc;
    } fetch_pkt_t;

    typedef struct packed {
        rv32i_ctrl_t           ctrl;
        logic [xlen-1:0]       pc;
        logic [xlen-1:0]       rs1_val;
        logic [xlen-1:0]       rs2_val;
        logic [xlen-1:0]       imm;
        logic [reg_addr_w-1:0] rs1;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rd;
        logic                  br_en;
    } decode_pkt_t;

    typedef struct packed {
        logic                  we;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       data;
    } wb_pkt_t;

endpackage

`default_nettype wire

// ==== hdl/instr_intake.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_intake (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   in_req_i,
    input  rv32i_pkg::fetch_pkt_t  in_pkt_i,
    input  logic                   take_i,
    output logic                   in_ack_o,
    output logic                   full_o,
    output rv32i_pkg::fetch_pkt_t  held_pkt_o
);

    logic capture;

    // A new word is taken only between handshakes and with the holding register free
    assign capture = in_req_i && !in_ack_o && !full_o;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            in_ack_o <= 1'b0;
            full_o   <= 1'b0;
        end else begin
            if (capture) begin
                in_ack_o <= 1'b1;
                full_o   <= 1'b1;
            end else begin
                // Fetch is released regardless of whether issue has taken the word
                if (in_ack_o && !in_req_i) begin
                    in_ack_o <= 1'b0;
                end
                if (take_i) begin
                    full_o <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            held_pkt_o <= in_pkt_i;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/control_rom.sv ====
`timescale 1ns/1ps
`default_nettype none

module control_rom (
    input  logic [6:0]             opcode_i,
    input  logic [2:0]             funct3_i,
    input  logic [6:0]             funct7_i,
    output rv32i_pkg::rv32i_ctrl_t ctrl_o
);

    always_comb begin
        ctrl_o         = '0;
        ctrl_o.opcode  = rv32i_pkg::rv32i_opcode_t'(opcode_i);
        ctrl_o.cmp_op  = rv32i_pkg::cmp_beq;
        ctrl_o.cmp_src = rv32i_pkg::cmp_src_rs2;
        ctrl_o.imm_fmt = rv32i_pkg::imm_none;

        case (rv32i_pkg::rv32i_opcode_t'(opcode_i))
            rv32i_pkg::opc_lui, rv32i_pkg::opc_auipc: begin
                ctrl_o.imm_fmt = rv32i_pkg::imm_u;
                ctrl_o.rd_we   = 1'b1;
            end
            rv32i_pkg::opc_jal: begin
                ctrl_o.imm_fmt = rv32i_pkg::imm_j;
                ctrl_o.is_jump = 1'b1;
                ctrl_o.rd_we   = 1'b1;
            end
            rv32i_pkg::opc_jalr: begin
                ctrl_o.imm_fmt = rv32i_pkg::imm_i;
                ctrl_o.is_jump = 1'b1;
                ctrl_o.rd_we   = 1'b1;
                ctrl_o.illegal = (funct3_i != 3'b000);
            end
            rv32i_pkg::opc_branch: begin
                ctrl_o.imm_fmt   = rv32i_pkg::imm_b;
                ctrl_o.is_branch = 1'b1;
                ctrl_o.cmp_op    = rv32i_pkg::cmp_op_t'(funct3_i);
                ctrl_o.illegal   = (funct3_i == 3'b010) || (funct3_i == 3'b011);
            end
            rv32i_pkg::opc_load: begin
                ctrl_o.imm_fmt = rv32i_pkg::imm_i;
                ctrl_o.mem_rd  = 1'b1;
                ctrl_o.rd_we   = 1'b1;
            end
            rv32i_pkg::opc_store: begin
                ctrl_o.imm_fmt = rv32i_pkg::imm_s;
                ctrl_o.mem_wr  = 1'b1;
            end
            rv32i_pkg::opc_op_imm: begin
                ctrl_o.imm_fmt = rv32i_pkg::imm_i;
                ctrl_o.alu_op  = funct3_i;
                ctrl_o.rd_we   = 1'b1;
                // Only srli and srai carry a meaningful funct7 in the immediate
                ctrl_o.alu_alt = (funct3_i == 3'b101) && funct7_i[5];
                if (funct3_i == 3'b010) begin
                    ctrl_o.cmp_op  = rv32i_pkg::cmp_blt;
                    ctrl_o.cmp_src = rv32i_pkg::cmp_src_imm;
                end else if (funct3_i == 3'b011) begin
                    ctrl_o.cmp_op  = rv32i_pkg::cmp_bltu;
                    ctrl_o.cmp_src = rv32i_pkg::cmp_src_imm;
                end
            end
            rv32i_pkg::opc_op: begin
                ctrl_o.alu_op  = funct3_i;
                ctrl_o.alu_alt = funct7_i[5];
                ctrl_o.rd_we   = 1'b1;
                if (funct3_i == 3'b010) begin
                    ctrl_o.cmp_op = rv32i_pkg::cmp_blt;
                end else if (funct3_i == 3'b011) begin
                    ctrl_o.cmp_op = rv32i_pkg::cmp_bltu;
                end
            end
            default: begin
                ctrl_o.illegal = 1'b1;
            end
        endcase

        // An illegal word must not cause any architectural side effect
        if (ctrl_o.illegal) begin
            ctrl_o.rd_we     = 1'b0;
            ctrl_o.mem_rd    = 1'b0;
            ctrl_o.mem_wr    = 1'b0;
            ctrl_o.is_branch = 1'b0;
            ctrl_o.is_jump   = 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  logic                             clk,
    input  logic                             rst_n_i,
    input  rv32i_pkg::wb_pkt_t               wb_i,
    input  logic [rv32i_pkg::reg_addr_w-1:0] rs1_i,
    input  logic [rv32i_pkg::reg_addr_w-1:0] rs2_i,
    output logic [rv32i_pkg::xlen-1:0]       rs1_val_o,
    output logic [rv32i_pkg::xlen-1:0]       rs2_val_o
);

    logic [rv32i_pkg::xlen-1:0] regs [rv32i_pkg::reg_count];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int k = 0; k < rv32i_pkg::reg_count; k++) begin
                regs[k] <= '0;
            end
        end else if (wb_i.we && (wb_i.rd != '0)) begin
            regs[wb_i.rd] <= wb_i.data;
        end
    end

    // x0 reads zero because its entry is cleared at reset and never written
    assign rs1_val_o = regs[rs1_i];
    assign rs2_val_o = regs[rs2_i];

endmodule

`default_nettype wire

// ==== hdl/branch_cmp.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_cmp (
    input  rv32i_pkg::cmp_op_t         cmp_op_i,
    input  logic [rv32i_pkg::xlen-1:0] a_i,
    input  logic [rv32i_pkg::xlen-1:0] b_i,
    output logic                       br_en_o
);

    logic lt_s;
    logic lt_u;

    assign lt_s = $signed(a_i) < $signed(b_i);
    assign lt_u = a_i < b_i;

    always_comb begin
        case (cmp_op_i)
            rv32i_pkg::cmp_beq:  br_en_o = (a_i == b_i);
            rv32i_pkg::cmp_bne:  br_en_o = (a_i != b_i);
            rv32i_pkg::cmp_blt:  br_en_o = lt_s;
            rv32i_pkg::cmp_bge:  br_en_o = !lt_s;
            rv32i_pkg::cmp_bltu: br_en_o = lt_u;
            rv32i_pkg::cmp_bgeu: br_en_o = !lt_u;
            default:             br_en_o = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  rv32i_pkg::fetch_pkt_t  fetch_i,
    input  rv32i_pkg::wb_pkt_t     wb_i,
    output rv32i_pkg::decode_pkt_t dec_o
);

    rv32i_pkg::rv32i_instr_u    instr;
    rv32i_pkg::rv32i_ctrl_t     ctrl;
    logic [rv32i_pkg::xlen-1:0] imm;
    logic [rv32i_pkg::xlen-1:0] rs1_val;
    logic [rv32i_pkg::xlen-1:0] rs2_val;
    logic [rv32i_pkg::xlen-1:0] cmp_b;
    logic                       br_en;

    assign instr = fetch_i.instr;

    always_comb begin
        case (ctrl.imm_fmt)
            rv32i_pkg::imm_i: imm = {{(rv32i_pkg::xlen-12){instr.i.imm_11_0[11]}},
                                     instr.i.imm_11_0};
            rv32i_pkg::imm_s: imm = {{(rv32i_pkg::xlen-12){instr.s.imm_11_5[6]}},
                                     instr.s.imm_11_5, instr.s.imm_4_0};
            rv32i_pkg::imm_b: imm = {{(rv32i_pkg::xlen-12){instr.b.imm_12}},
                                     instr.b.imm_11, instr.b.imm_10_5,
                                     instr.b.imm_4_1, 1'b0};
            rv32i_pkg::imm_u: imm = {instr.u.imm_31_12, 12'h000};
            rv32i_pkg::imm_j: imm = {{(rv32i_pkg::xlen-20){instr.j.imm_20}},
                                     instr.j.imm_19_12, instr.j.imm_11,
                                     instr.j.imm_10_1, 1'b0};
            default:          imm = '0;
        endcase
    end

    // slti and sltiu compare against the immediate instead of rs2
    assign cmp_b = (ctrl.cmp_src == rv32i_pkg::cmp_src_imm) ? imm : rs2_val;

    control_rom control_rom_i (
        .opcode_i (instr.r.opcode),
        .funct3_i (instr.r.funct3),
        .funct7_i (instr.r.funct7),
        .ctrl_o   (ctrl)
    );

    branch_cmp branch_cmp_i (
        .cmp_op_i (ctrl.cmp_op),
        .a_i      (rs1_val),
        .b_i      (cmp_b),
        .br_en_o  (br_en)
    );

    regfile regfile_i (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .wb_i      (wb_i),
        .rs1_i     (instr.r.rs1),
        .rs2_i     (instr.r.rs2),
        .rs1_val_o (rs1_val),
        .rs2_val_o (rs2_val)
    );

    always_comb begin
        dec_o.ctrl    = ctrl;
        dec_o.pc      = fetch_i.pc;
        dec_o.rs1_val = rs1_val;
        dec_o.rs2_val = rs2_val;
        dec_o.imm     = imm;
        dec_o.rs1     = instr.r.rs1;
        dec_o.rs2     = instr.r.rs2;
        dec_o.rd      = instr.r.rd;
        dec_o.br_en   = br_en;
    end

endmodule

`default_nettype wire

// ==== hdl/decode_issue.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_issue (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   full_i,
    input  rv32i_pkg::decode_pkt_t dec_i,
    input  logic                   out_ack_i,
    output logic                   take_o,
    output logic                   out_req_o,
    output rv32i_pkg::decode_pkt_t out_pkt_o
);

    typedef enum logic [1:0] {
        st_empty,
        st_req,
        st_ack_fall
    } issue_state_t;

    issue_state_t state_q;

    // The slot loads on the same edge that clears the intake holding register
    assign take_o    = full_i && (state_q == st_empty);
    assign out_req_o = (state_q == st_req);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= st_empty;
        end else begin
            case (state_q)
                st_empty:    if (take_o) state_q <= st_req;
                st_req:      if (out_ack_i) state_q <= st_ack_fall;
                st_ack_fall: if (!out_ack_i) state_q <= st_empty;
                default:     state_q <= st_empty;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take_o) begin
            out_pkt_o <= dec_i;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/decode_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_top (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   in_req_i,
    input  rv32i_pkg::fetch_pkt_t  in_pkt_i,
    input  rv32i_pkg::wb_pkt_t     wb_i,
    input  logic                   out_ack_i,
    output logic                   in_ack_o,
    output logic                   out_req_o,
    output rv32i_pkg::decode_pkt_t out_pkt_o
);

    rv32i_pkg::fetch_pkt_t  held_pkt;
    rv32i_pkg::decode_pkt_t dec_pkt;
    logic                   full;
    logic                   take;

    instr_intake instr_intake_i (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .in_req_i   (in_req_i),
        .in_pkt_i   (in_pkt_i),
        .take_i     (take),
        .in_ack_o   (in_ack_o),
        .full_o     (full),
        .held_pkt_o (held_pkt)
    );

    decode_stage decode_stage_i (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .fetch_i (held_pkt),
        .wb_i    (wb_i),
        .dec_o   (dec_pkt)
    );

    decode_issue decode_issue_i (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .full_i    (full),
        .dec_i     (dec_pkt),
        .out_ack_i (out_ack_i),
        .take_o    (take),
        .out_req_o (out_req_o),
        .out_pkt_o (out_pkt_o)
    );

endmodule

`default_nettype wire

// ==== verification/decode_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_sva (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   in_req_i,
    input  logic                   in_ack_o,
    input  logic                   out_req_o,
    input  logic                   out_ack_i,
    input  rv32i_pkg::decode_pkt_t out_pkt_o
);

    ack_follows_req: assert property (@(posedge clk) disable iff (!rst_n_i)
        $rose(in_ack_o) |-> $past(in_req_i))
        else $error("in_ack_o rose while in_req_i was low");

    // The packet must not move under a pending request
    out_pkt_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
        (out_req_o && $past(out_req_o)) |-> $stable(out_pkt_o))
        else $error("out_pkt_o changed while out_req_o was high");

    req_held_until_ack: assert property (@(posedge clk) disable iff (!rst_n_i)
        (out_req_o && !out_ack_i) |=> out_req_o)
        else $error("out_req_o dropped before out_ack_i");

    idle_after_reset: assert property (@(posedge clk)
        $rose(rst_n_i) |-> (!in_ack_o && !out_req_o))
        else $error("handshake outputs not low after reset");

endmodule

bind decode_top decode_sva decode_sva_i (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .in_req_i  (in_req_i),
    .in_ack_o  (in_ack_o),
    .out_req_o (out_req_o),
    .out_ack_i (out_ack_i),
    .out_pkt_o (out_pkt_o)
);

`default_nettype wire

// ==== verification/tb_decode_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_decode_top;

    localparam int num_instr   = 400;
    localparam int cycle_limit = 40 * num_instr + 100;

    logic                   clk;
    logic                   rst_n_i;
    logic                   in_req_i;
    rv32i_pkg::fetch_pkt_t  in_pkt_i;
    rv32i_pkg::wb_pkt_t     wb_i;
    logic                   out_ack_i;
    logic                   in_ack_o;
    logic                   out_req_o;
    rv32i_pkg::decode_pkt_t out_pkt_o;

    logic [rv32i_pkg::xlen-1:0] model_regs [rv32i_pkg::reg_count];
    rv32i_pkg::decode_pkt_t     exp_q [$];
    logic [31:0]                gen_seed;
    logic [31:0]                ack_seed;
    int                         rx_count;
    int                         cycle_count;
    int                         handshakes;
    bit                         req_prev;

    decode_top decode_top_i (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .in_req_i  (in_req_i),
        .in_pkt_i  (in_pkt_i),
        .wb_i      (wb_i),
        .out_ack_i (out_ack_i),
        .in_ack_o  (in_ack_o),
        .out_req_o (out_req_o),
        .out_pkt_o (out_pkt_o)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic relation_holds(input logic [2:0] op, input logic [31:0] a,
                                            input logic [31:0] b);
        case (op)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            3'b111:  return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // Expected packet built from the ISA bit positions and the model register array
    function automatic rv32i_pkg::decode_pkt_t ref_decode(input logic [31:0] w,
                                                          input logic [31:0] pc);
        rv32i_pkg::decode_pkt_t p;
        logic [2:0]             f3;
        logic [31:0]            b_op;
        p  = '0;
        f3 = w[14:12];
        p.ctrl.opcode = rv32i_pkg::rv32i_opcode_t'(w[6:0]);
        case (p.ctrl.opcode)
            rv32i_pkg::opc_lui, rv32i_pkg::opc_auipc: begin
                p.ctrl.imm_fmt = rv32i_pkg::imm_u;
                p.ctrl.rd_we   = 1'b1;
            end
            rv32i_pkg::opc_jal: begin
                p.ctrl.imm_fmt = rv32i_pkg::imm_j;
                p.ctrl.is_jump = 1'b1;
                p.ctrl.rd_we   = 1'b1;
            end
            rv32i_pkg::opc_jalr: begin
                p.ctrl.imm_fmt = rv32i_pkg::imm_i;
                p.ctrl.is_jump = 1'b1;
                p.ctrl.rd_we   = 1'b1;
                p.ctrl.illegal = f3 != 3'b000;
            end
            rv32i_pkg::opc_branch: begin
                p.ctrl.imm_fmt   = rv32i_pkg::imm_b;
                p.ctrl.is_branch = 1'b1;
                p.ctrl.cmp_op    = rv32i_pkg::cmp_op_t'(f3);
                p.ctrl.illegal   = f3[2:1] == 2'b01;
            end
            rv32i_pkg::opc_load: begin
                p.ctrl.imm_fmt = rv32i_pkg::imm_i;
                p.ctrl.mem_rd  = 1'b1;
                p.ctrl.rd_we   = 1'b1;
            end
            rv32i_pkg::opc_store: begin
                p.ctrl.imm_fmt = rv32i_pkg::imm_s;
                p.ctrl.mem_wr  = 1'b1;
            end
            rv32i_pkg::opc_op_imm, rv32i_pkg::opc_op: begin
                p.ctrl.alu_op = f3;
                p.ctrl.rd_we  = 1'b1;
                if (p.ctrl.opcode == rv32i_pkg::opc_op_imm) begin
                    p.ctrl.imm_fmt = rv32i_pkg::imm_i;
                    p.ctrl.alu_alt = (f3 == 3'b101) && w[30];
                    p.ctrl.cmp_src = (f3[2:1] == 2'b01) ? rv32i_pkg::cmp_src_imm
                                                        : rv32i_pkg::cmp_src_rs2;
                end else begin
                    p.ctrl.alu_alt = w[30];
                end
                if (f3 == 3'b010) p.ctrl.cmp_op = rv32i_pkg::cmp_blt;
                if (f3 == 3'b011) p.ctrl.cmp_op = rv32i_pkg::cmp_bltu;
            end
            default: p.ctrl.illegal = 1'b1;
        endcase
        if (p.ctrl.illegal) begin
            p.ctrl.rd_we     = 1'b0;
            p.ctrl.mem_rd    = 1'b0;
            p.ctrl.mem_wr    = 1'b0;
            p.ctrl.is_branch = 1'b0;
            p.ctrl.is_jump   = 1'b0;
        end
        case (p.ctrl.imm_fmt)
            rv32i_pkg::imm_i: p.imm = {{20{w[31]}}, w[31:20]};
            rv32i_pkg::imm_s: p.imm = {{20{w[31]}}, w[31:25], w[11:7]};
            rv32i_pkg::imm_b: p.imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            rv32i_pkg::imm_u: p.imm = {w[31:12], 12'h000};
            rv32i_pkg::imm_j: p.imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            default:          p.imm = '0;
        endcase
        p.pc      = pc;
        p.rs1     = w[19:15];
        p.rs2     = w[24:20];
        p.rd      = w[11:7];
        p.rs1_val = model_regs[p.rs1];
        p.rs2_val = model_regs[p.rs2];
        b_op      = (p.ctrl.cmp_src == rv32i_pkg::cmp_src_imm) ? p.imm : p.rs2_val;
        p.br_en   = relation_holds(p.ctrl.cmp_op, p.rs1_val, b_op);
        return p;
    endfunction

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check_ctrl(input string name, input rv32i_pkg::rv32i_ctrl_t want,
                              input rv32i_pkg::rv32i_ctrl_t got);
        if (got !== want) begin
            stop_with_error($sformatf("MISMATCH at %0t: %s expected %h actual %h",
                                      $time, name, want, got));
        end
    endtask

    task automatic check_word(input string name, input logic [rv32i_pkg::xlen-1:0] want,
                              input logic [rv32i_pkg::xlen-1:0] got);
        if (got !== want) begin
            stop_with_error($sformatf("MISMATCH at %0t: %s expected %h actual %h",
                                      $time, name, want, got));
        end
    endtask

    task automatic check_bit(input string name, input logic want, input logic got);
        if (got !== want) begin
            stop_with_error($sformatf("MISMATCH at %0t: %s expected %b actual %b",
                                      $time, name, want, got));
        end
    endtask

    task automatic gen_rand(output logic [31:0] r);
        gen_seed = lcg_step(gen_seed);
        r[31:16] = gen_seed[31:16];
        gen_seed = lcg_step(gen_seed);
        r[15:0]  = gen_seed[31:16];
    endtask

    // Random fields with one of the nine opcodes or one of eight unused ones
    task automatic make_instr(output logic [31:0] w);
        logic [31:0] sel;
        int          choice;
        gen_rand(w);
        gen_rand(sel);
        choice = int'(sel[31:16]) % 11;
        case (choice)
            0:       w[6:0] = rv32i_pkg::opc_lui;
            1:       w[6:0] = rv32i_pkg::opc_auipc;
            2:       w[6:0] = rv32i_pkg::opc_jal;
            3:       w[6:0] = rv32i_pkg::opc_jalr;
            4:       w[6:0] = rv32i_pkg::opc_branch;
            5:       w[6:0] = rv32i_pkg::opc_load;
            6:       w[6:0] = rv32i_pkg::opc_store;
            7:       w[6:0] = rv32i_pkg::opc_op_imm;
            8:       w[6:0] = rv32i_pkg::opc_op;
            default: begin
                case (sel[2:0])
                    3'd0:    w[6:0] = 7'h0F;
                    3'd1:    w[6:0] = 7'h73;
                    3'd2:    w[6:0] = 7'h2F;
                    3'd3:    w[6:0] = 7'h00;
                    3'd4:    w[6:0] = 7'h7F;
                    3'd5:    w[6:0] = 7'h53;
                    3'd6:    w[6:0] = 7'h5B;
                    default: w[6:0] = 7'h07;
                endcase
            end
        endcase
        if ((w[6:0] == rv32i_pkg::opc_jalr) && sel[3]) begin
            w[14:12] = 3'b000;
        end
    endtask

    task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
        wb_i.we   = 1'b1;
        wb_i.rd   = addr;
        wb_i.data = data;
        @(posedge clk);
        #1;
        if (addr != 5'd0) begin
            model_regs[addr] = data;
        end
    endtask

    // Drives the four-phase fetch side and is entered and left 1 ns after a rising edge
    task automatic send_instr(input logic [31:0] word, input logic [31:0] pc);
        in_pkt_i.instr.raw = word;
        in_pkt_i.pc        = pc;
        in_req_i           = 1'b1;
        @(posedge clk);
        #1;
        while (!in_ack_o) begin
            @(posedge clk);
            #1;
        end
        in_req_i = 1'b0;
        @(posedge clk);
        #1;
        while (in_ack_o) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic compare_packet();
        rv32i_pkg::decode_pkt_t want;
        if (exp_q.size() == 0) begin
            stop_with_error("A packet arrived on the output with no instruction outstanding");
        end else begin
            want = exp_q.pop_front();
            check_ctrl("ctrl", want.ctrl, out_pkt_o.ctrl);
            check_word("pc", want.pc, out_pkt_o.pc);
            check_word("rs1_val", want.rs1_val, out_pkt_o.rs1_val);
            check_word("rs2_val", want.rs2_val, out_pkt_o.rs2_val);
            check_word("imm", want.imm, out_pkt_o.imm);
            check_word("rs1", 32'(want.rs1), 32'(out_pkt_o.rs1));
            check_word("rs2", 32'(want.rs2), 32'(out_pkt_o.rs2));
            check_word("rd", 32'(want.rd), 32'(out_pkt_o.rd));
            check_bit("br_en", want.br_en, out_pkt_o.br_en);
            rx_count++;
        end
    endtask

    always begin
        @(posedge clk);
        #1;
        if (out_req_o && !req_prev) begin
            compare_packet();
        end
        req_prev = out_req_o;
    end

    // Every other group of fifty handshakes on the execute side uses long ack delays
    always begin : execute_responder
        int delay;
        @(posedge clk);
        #1;
        if (out_req_o && !out_ack_i) begin
            ack_seed = lcg_step(ack_seed);
            if ((handshakes % 100) >= 50) begin
                delay = 6 + int'(ack_seed[31:16]) % 10;
            end else begin
                delay = int'(ack_seed[31:16]) % 6;
            end
            for (int d = 0; d < delay; d++) begin
                @(posedge clk);
                #1;
            end
            out_ack_i = 1'b1;
            @(posedge clk);
            #1;
            while (out_req_o) begin
                @(posedge clk);
                #1;
            end
            out_ack_i = 1'b0;
            handshakes++;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            stop_with_error($sformatf("Timeout after %0d cycles, %0d of %0d packets received",
                                      cycle_count, rx_count, num_instr));
        end
    end

    initial begin
        logic [31:0] word;
        logic [31:0] r;
        logic [31:0] data;
        logic [4:0]  addr;
        clk       = 1'b0;
        rst_n_i   = 1'b0;
        in_req_i  = 1'b0;
        in_pkt_i  = '0;
        wb_i      = '0;
        out_ack_i = 1'b0;
        gen_seed  = 32'd54305;
        ack_seed  = 32'd54305;
        model_regs[5'd0] = '0;
        repeat (4) @(posedge clk);
        #1;
        rst_n_i = 1'b1;

        // Mix of small, extreme, random and repeated values so equal operands occur
        for (int k = 0; k < rv32i_pkg::reg_count; k++) begin
            addr = 5'(k);
            gen_rand(r);
            case (addr)
                5'd0:             data = r | 32'h1;
                5'd1, 5'd2, 5'd3: data = {{28{r[3]}}, r[3:0]};
                5'd4:             data = 32'h8000_0000;
                5'd5:             data = 32'h7FFF_FFFF;
                5'd6:             data = 32'hFFFF_FFFF;
                default:          data = (addr >= 5'd24) ? model_regs[addr - 5'd8] : r;
            endcase
            write_reg(addr, data);
        end
        wb_i = '0;

        for (int n = 0; n < num_instr; n++) begin
            make_instr(word);
            exp_q.push_back(ref_decode(word, 32'h0000_1000 + 32'(4 * n)));
            send_instr(word, 32'h0000_1000 + 32'(4 * n));
        end
        while (rx_count < num_instr) begin
            @(posedge clk);
            #1;
        end
        repeat (10) @(posedge clk);
        if ((rx_count == num_instr) && (exp_q.size() == 0)) begin
            $display("No errors");
            $finish;
        end else begin
            stop_with_error("The packet count does not match the number of instructions sent");
        end
    end

endmodule

`default_nettype wire

// ==== tb.f ====
hdl/rv32i_pkg.sv
hdl/instr_intake.sv
hdl/control_rom.sv
hdl/regfile.sv
hdl/branch_cmp.sv
hdl/decode_stage.sv
hdl/decode_issue.sv
hdl/decode_top.sv
verification/decode_sva.sv
verification/tb_decode_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

sim_log=sim.log

verilator --binary --timing --assert -f tb.f --top-module tb_decode_top > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "FAIL: Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_decode_top > "$sim_log" 2>&1
sim_status=$?
cat "$sim_log"
if [ $sim_status -ne 0 ]; then
    echo "FAIL: simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^No errors$" "$sim_log"; then
    echo "PASS"
    exit 0
fi
echo "FAIL: pass message not found in $sim_log"
exit 1
